// ==== source/ahb_defs_pkg.sv ====
// AHB-Lite bus package with transfer codes, response codes and bus word types
package ahb_defs_pkg;

    typedef logic [31 : 0]  ahb_word_t;     // Bus data word
    typedef logic [31 : 0]  ahb_addr_t;     // Bus byte address

    // HTRANS transfer types
    typedef logic [1  : 0]  htrans_t;

    localparam htrans_t HTRANS_IDLE   = 2'b00;  // No transfer
    localparam htrans_t HTRANS_BUSY   = 2'b01;  // Master inserts idle beat
    localparam htrans_t HTRANS_NONSEQ = 2'b10;  // First or single beat
    localparam htrans_t HTRANS_SEQ    = 2'b11;  // Burst continuation

    // HRESP is one bit wide on AHB-Lite
    typedef logic           hresp_t;

    localparam hresp_t  HRESP_OKAY    = 1'b0;   // Transfer done
    localparam hresp_t  HRESP_ERROR   = 1'b1;   // Two-cycle error

endpackage : ahb_defs_pkg

// ==== source/pwm_defs_pkg.sv ====
// PWM package with register map offsets, control fields, mixer modes and dead-time type
package pwm_defs_pkg;

    // Word offset taken from haddr[4:2]
    typedef logic [2  : 0]  reg_off_t;

    localparam reg_off_t REG_CTRL     = 3'd0;   // Enable and mode
    localparam reg_off_t REG_PERIOD_A = 3'd1;   // Channel A period
    localparam reg_off_t REG_DUTY_A   = 3'd2;   // Channel A duty
    localparam reg_off_t REG_PERIOD_B = 3'd3;   // Channel B period
    localparam reg_off_t REG_DUTY_B   = 3'd4;   // Channel B duty
    localparam reg_off_t REG_DEAD     = 3'd5;   // Dead time, COMPL only

    // Field positions inside REG_CTRL
    localparam int CTRL_EN      = 0;            // Global enable
    localparam int CTRL_MODE_LO = 1;            // Mode field low bit
    localparam int CTRL_MODE_HI = 2;            // Mode field high bit

    // Output mixer mode, code 3 is reserved and acts as MODE_INDEP
    typedef enum logic [1 : 0] {
        MODE_INDEP = 2'd0,                      // Pins follow own channel
        MODE_COMPL = 2'd1,                      // A and not A with dead time
        MODE_GATED = 2'd2                       // A masked by B
    } pwm_mode_t;

    typedef logic [3  : 0]  dead_t;             // Dead-time clock count

endpackage : pwm_defs_pkg

// ==== source/pwm_cfg_if.sv ====
// PWM configuration bus from the register block to the channels and the output mixer
interface pwm_cfg_if
#(
    parameter int pwm_width = 8                 // Counter, period and duty width
);
    import pwm_defs_pkg::*;

    logic                       enable;         // Channels run while high
    pwm_mode_t                  mode;           // Mixer combine rule
    logic   [pwm_width-1 : 0]   period_a;       // Last count of channel A
    logic   [pwm_width-1 : 0]   duty_a;         // High clocks of channel A
    logic   [pwm_width-1 : 0]   period_b;       // Last count of channel B
    logic   [pwm_width-1 : 0]   duty_b;         // High clocks of channel B
    dead_t                      dead;           // Blanking after raw_a edges

    // Register block side
    modport regs (
        output  enable, mode, period_a, duty_a, period_b, duty_b, dead
    );

    // Channel and mixer side
    modport chan (
        input   enable, mode, period_a, duty_a, period_b, duty_b, dead
    );

endinterface : pwm_cfg_if

// ==== source/ahb_pwm_regs.sv ====
// AHB-Lite slave holding the PWM register file with read-back and two-cycle error response
module ahb_pwm_regs
#(
    parameter int pwm_width = 8                             // Period and duty width
)(
    input   logic                       hclk,               // Bus clock
    input   logic                       rst_n,              // Sync reset, active low
    input   ahb_defs_pkg::ahb_addr_t    haddr,              // Byte address
    input   ahb_defs_pkg::htrans_t      htrans,             // Transfer type
    input   logic                       hwrite,             // 1 = write
    input   logic                       hsel,               // Slave select
    input   logic                       hready,             // Bus ready in
    input   ahb_defs_pkg::ahb_word_t    hwdata,             // Write data, data phase
    output  ahb_defs_pkg::ahb_word_t    hrdata,             // Read data, data phase
    output  logic                       hreadyout,          // Low in first error cycle
    output  ahb_defs_pkg::hresp_t       hresp,              // OKAY or ERROR
    pwm_cfg_if.regs                     cfg                 // Settings to datapath
);
    import ahb_defs_pkg::*;
    import pwm_defs_pkg::*;

    typedef enum logic { RESP_OK, RESP_ERR2 } resp_state_t;

    resp_state_t    resp_state;                             // Error response phase
    logic           trans_ok;                               // NONSEQ or SEQ
    logic           addr_ok;                                // Address phase accepted
    logic           dp_valid;                               // Data phase in progress
    logic           dp_write;                               // Data phase is a write
    reg_off_t       dp_off;                                 // Captured word offset
    logic           dp_mapped;                              // Offset hits a register
    ahb_word_t      rd_mux;                                 // Register selected by dp_off
    logic           err_start;                              // First error cycle
    logic           wr_en;                                  // Register write strobe

    always_comb begin
        case (htrans)
            HTRANS_NONSEQ,
            HTRANS_SEQ:     trans_ok = 1'b1;                // Real transfer
            HTRANS_IDLE,
            HTRANS_BUSY:    trans_ok = 1'b0;                // Nothing to do
        endcase
    end

    assign addr_ok = hsel && hready && trans_ok;

    // Address phase capture
    always_ff @(posedge hclk) begin
        if (!rst_n) begin
            dp_valid <= 1'b0;
            dp_write <= 1'b0;
        end else if (hready) begin                          // Held over error stall
            dp_valid <= addr_ok;
            dp_write <= hwrite;
        end
    end

    always_ff @(posedge hclk) begin
        if (hready) begin
            dp_off <= haddr[4:2];                           // Word offset only
        end
    end

    // Offset decode and read mux, unused bits stay zero
    always_comb begin
        rd_mux    = '0;
        dp_mapped = 1'b1;
        case (dp_off)
            REG_CTRL: begin
                rd_mux[CTRL_EN]                     = cfg.enable;
                rd_mux[CTRL_MODE_HI : CTRL_MODE_LO] = cfg.mode;
            end
            REG_PERIOD_A:   rd_mux[pwm_width-1 : 0] = cfg.period_a;
            REG_DUTY_A:     rd_mux[pwm_width-1 : 0] = cfg.duty_a;
            REG_PERIOD_B:   rd_mux[pwm_width-1 : 0] = cfg.period_b;
            REG_DUTY_B:     rd_mux[pwm_width-1 : 0] = cfg.duty_b;
            REG_DEAD:       rd_mux[$bits(dead_t)-1 : 0] = cfg.dead;
            default:        dp_mapped = 1'b0;               // Offsets 6 and 7
        endcase
    end

    assign wr_en  = dp_valid && dp_write && dp_mapped;
    assign hrdata = (dp_valid && !dp_write) ? rd_mux : '0;

    // Register file, write lands at end of data phase
    always_ff @(posedge hclk) begin
        if (!rst_n) begin
            cfg.enable   <= 1'b0;
            cfg.mode     <= MODE_INDEP;
            cfg.period_a <= '0;
            cfg.duty_a   <= '0;
            cfg.period_b <= '0;
            cfg.duty_b   <= '0;
            cfg.dead     <= '0;
        end else if (wr_en) begin
            case (dp_off)
                REG_CTRL: begin
                    cfg.enable <= hwdata[CTRL_EN];
                    cfg.mode   <= pwm_mode_t'(hwdata[CTRL_MODE_HI : CTRL_MODE_LO]);
                end
                REG_PERIOD_A:   cfg.period_a <= hwdata[pwm_width-1 : 0];
                REG_DUTY_A:     cfg.duty_a   <= hwdata[pwm_width-1 : 0];
                REG_PERIOD_B:   cfg.period_b <= hwdata[pwm_width-1 : 0];
                REG_DUTY_B:     cfg.duty_b   <= hwdata[pwm_width-1 : 0];
                REG_DEAD:       cfg.dead     <= hwdata[$bits(dead_t)-1 : 0];
                default:        ;                           // Unreachable, wr_en needs a hit
            endcase
        end
    end

    // Error response sequencing
    assign err_start = (resp_state == RESP_OK) && dp_valid && !dp_mapped;

    always_ff @(posedge hclk) begin
        if (!rst_n) begin
            resp_state <= RESP_OK;
        end else begin
            case (resp_state)
                RESP_OK:    if (err_start) resp_state <= RESP_ERR2;
                RESP_ERR2:  resp_state <= RESP_OK;          // Always one cycle
            endcase
        end
    end

    assign hreadyout = !err_start;                          // Stall only in first cycle
    assign hresp     = (err_start || resp_state == RESP_ERR2) ? HRESP_ERROR : HRESP_OKAY;

endmodule : ahb_pwm_regs

// ==== source/pwm_channel.sv ====
// PWM channel generator with a wrapping period counter and a registered duty compare
module pwm_channel
#(
    parameter int pwm_width = 8                     // Counter width
)(
    input   logic                       hclk,       // Clock
    input   logic                       rst_n,      // Sync reset, active low
    input   logic                       enable,     // Run counter
    input   logic   [pwm_width-1 : 0]   period,     // Last count before wrap
    input   logic   [pwm_width-1 : 0]   duty,       // High clocks per cycle
    output  logic                       pwm_out     // Registered raw output
);

    typedef logic [pwm_width-1 : 0] cnt_t;

    cnt_t   cnt;                                    // Position in current cycle
    logic   wrap;                                   // Last count reached

    // Also catches a period lowered below the running count
    assign wrap = (cnt >= period);

    always_ff @(posedge hclk) begin
        if (!rst_n) begin
            cnt     <= '0;
            pwm_out <= 1'b0;
        end else if (!enable) begin                 // Idle, restart from zero
            cnt     <= '0;
            pwm_out <= 1'b0;
        end else begin
            if (wrap) begin
                cnt <= '0;                          // period+1 clocks per cycle
            end else begin
                cnt <= cnt + 1'b1;
            end
            pwm_out <= (cnt < duty);                // High for min(duty, period+1)
        end
    end

endmodule : pwm_channel

// ==== source/pwm_output_mix.sv ====
// PWM output mixer combining both channels by mode with dead-time insertion on channel A edges
module pwm_output_mix
(
    input   logic       hclk,                           // Clock
    input   logic       rst_n,                          // Sync reset, active low
    pwm_cfg_if.chan     cfg,                            // Mode, dead time, enable
    input   logic       raw_a,                          // Channel A output
    input   logic       raw_b,                          // Channel B output
    output  logic       pwm_a,                          // Pin A
    output  logic       pwm_b                           // Pin B
);
    import pwm_defs_pkg::*;

    logic   raw_a_d;                                    // raw_a one clock back
    logic   a_edge;                                     // Any raw_a transition
    dead_t  dead_cnt;                                   // Remaining blank clocks
    logic   blank;                                      // Hold both pins low next clock
    logic   nxt_a;
    logic   nxt_b;

    assign a_edge = raw_a ^ raw_a_d;

    // Edge clock blanks if dead is nonzero, then dead-1 more from the counter
    assign blank  = a_edge ? (cfg.dead != '0) : (dead_cnt > dead_t'(1));

    always_comb begin
        case (cfg.mode)
            MODE_COMPL: begin
                nxt_a = raw_a  && !blank;
                nxt_b = !raw_a && !blank;               // Channel B unused here
            end
            MODE_GATED: begin
                nxt_a = raw_a && raw_b;
                nxt_b = raw_b;
            end
            default: begin                              // INDEP and reserved code
                nxt_a = raw_a;
                nxt_b = raw_b;
            end
        endcase
    end

    always_ff @(posedge hclk) begin
        if (!rst_n || !cfg.enable) begin                // Pins low while disabled
            raw_a_d  <= 1'b0;
            dead_cnt <= '0;
            pwm_a    <= 1'b0;
            pwm_b    <= 1'b0;
        end else begin
            raw_a_d <= raw_a;
            if (a_edge) begin
                dead_cnt <= cfg.dead;                   // Restart blanking window
            end else if (dead_cnt != '0) begin
                dead_cnt <= dead_cnt - 1'b1;
            end
            pwm_a <= nxt_a;
            pwm_b <= nxt_b;
        end
    end

endmodule : pwm_output_mix

// ==== source/ahb_pwm_top.sv ====
// Two-channel PWM peripheral top with AHB-Lite slave, two generators and output mixer
module ahb_pwm_top
#(
    parameter int pwm_width = 8                             // Counter, period and duty width
)(
    input   logic                       hclk,               // Bus and PWM clock
    input   logic                       rst_n,              // Sync reset, active low
    input   ahb_defs_pkg::ahb_addr_t    haddr,              // AHB HADDR
    input   ahb_defs_pkg::htrans_t      htrans,             // AHB HTRANS
    input   logic                       hwrite,             // AHB HWRITE
    input   logic                       hsel,               // AHB HSEL
    input   logic                       hready,             // AHB HREADY
    input   ahb_defs_pkg::ahb_word_t    hwdata,             // AHB HWDATA
    output  ahb_defs_pkg::ahb_word_t    hrdata,             // AHB HRDATA
    output  logic                       hreadyout,          // AHB HREADYOUT
    output  ahb_defs_pkg::hresp_t       hresp,              // AHB HRESP
    output  logic                       pwm_a,              // Pin A
    output  logic                       pwm_b               // Pin B
);

    logic   raw_a;                                          // Channel A to mixer
    logic   raw_b;                                          // Channel B to mixer

    pwm_cfg_if #(.pwm_width(pwm_width)) cfg_bus ();

    ahb_pwm_regs #(
        .pwm_width  ( pwm_width         )
    ) regs (
        .hclk       ( hclk              ),
        .rst_n      ( rst_n             ),
        .haddr      ( haddr             ),
        .htrans     ( htrans            ),
        .hwrite     ( hwrite            ),
        .hsel       ( hsel              ),
        .hready     ( hready            ),
        .hwdata     ( hwdata            ),
        .hrdata     ( hrdata            ),
        .hreadyout  ( hreadyout         ),
        .hresp      ( hresp             ),
        .cfg        ( cfg_bus.regs      )                   // Drives all settings
    );

    pwm_channel #(
        .pwm_width  ( pwm_width         )
    ) ch_a (
        .hclk       ( hclk              ),
        .rst_n      ( rst_n             ),
        .enable     ( cfg_bus.enable    ),
        .period     ( cfg_bus.period_a  ),
        .duty       ( cfg_bus.duty_a    ),
        .pwm_out    ( raw_a             )
    );

    pwm_channel #(
        .pwm_width  ( pwm_width         )
    ) ch_b (
        .hclk       ( hclk              ),
        .rst_n      ( rst_n             ),
        .enable     ( cfg_bus.enable    ),
        .period     ( cfg_bus.period_b  ),
        .duty       ( cfg_bus.duty_b    ),
        .pwm_out    ( raw_b             )
    );

    pwm_output_mix mix (
        .hclk       ( hclk              ),
        .rst_n      ( rst_n             ),
        .cfg        ( cfg_bus.chan      ),                  // Mode, dead, enable
        .raw_a      ( raw_a             ),
        .raw_b      ( raw_b             ),
        .pwm_a      ( pwm_a             ),
        .pwm_b      ( pwm_b             )
    );

endmodule : ahb_pwm_top

// ==== verification/ahb_pwm_assert.sv ====
// Concurrent checks on the AHB-Lite error response and the PWM pin rules
module ahb_pwm_assert (
    input   logic                       hclk,               // Bus clock
    input   logic                       rst_n,              // Sync reset, active low
    input   logic                       hreadyout,          // Slave ready
    input   ahb_defs_pkg::hresp_t       hresp,              // Slave response
    input   logic                       enable,             // Global enable register
    input   pwm_defs_pkg::pwm_mode_t    mode,               // Mixer mode register
    input   logic                       pwm_a,              // Pin A
    input   logic                       pwm_b               // Pin B
);
    import ahb_defs_pkg::*;
    import pwm_defs_pkg::*;

    // First error cycle stalls, second one completes
    err_two_cycle: assert property (@(posedge hclk) disable iff (!rst_n)
        (hresp == HRESP_ERROR && !hreadyout) |=> (hresp == HRESP_ERROR && hreadyout))
        else $error("ERROR response with hreadyout low not followed by its second cycle");

    compl_exclusive: assert property (@(posedge hclk) disable iff (!rst_n)
        (mode == MODE_COMPL) |-> !(pwm_a && pwm_b))
        else $error("Both pins high in complementary mode");

    // Pins are registered, so they clear one clock after enable drops
    idle_low: assert property (@(posedge hclk) disable iff (!rst_n)
        !enable |=> (!pwm_a && !pwm_b))
        else $error("A pin is high while the peripheral is disabled");

endmodule : ahb_pwm_assert

bind ahb_pwm_top ahb_pwm_assert chk (
    .hclk       ( hclk              ),
    .rst_n      ( rst_n             ),
    .hreadyout  ( hreadyout         ),
    .hresp      ( hresp             ),
    .enable     ( cfg_bus.enable    ),
    .mode       ( cfg_bus.mode      ),
    .pwm_a      ( pwm_a             ),
    .pwm_b      ( pwm_b             )
);

// ==== verification/ahb_pwm_tb.sv ====
// Directed testbench for the two-channel AHB-Lite PWM peripheral
module ahb_pwm_tb;
    import ahb_defs_pkg::*;
    import pwm_defs_pkg::*;

    localparam int pwm_width   = 8;
    localparam int clk_half    = 2;                         // 4 unit clock period
    localparam int k_periods   = 3;                         // Whole periods per window
    localparam int period_max  = 40;                        // Largest random period
    localparam int win_max     = k_periods * (period_max + 1);
    localparam int n_windows   = 8;                         // Measurement windows in all tests
    localparam int budget_clks = 10 + n_windows * (win_max + 200) + 400;

    logic       hclk;
    logic       rst_n;
    ahb_addr_t  haddr;
    htrans_t    htrans;
    logic       hwrite;
    logic       hsel;
    logic       hready;                                     // Fed back from hreadyout
    ahb_word_t  hwdata;
    ahb_word_t  hrdata;
    logic       hreadyout;
    hresp_t     hresp;
    logic       pwm_a;
    logic       pwm_b;

    int unsigned    seed = 86215;                           // LCG state
    int             errors;
    int             checks;
    int             test_errs;
    string          cur_test;
    ahb_word_t      shadow [0:7];                           // Expected register contents

    ahb_pwm_top #(.pwm_width(pwm_width)) UUT (.*);

    initial hclk = 1'b0;
    always #(clk_half) hclk = ~hclk;

    function automatic int unsigned next_rand();
        seed = seed * 32'd1103515245 + 32'd12345;
        return seed >> 8;                                   // Drop weak low bits
    endfunction

    function automatic int min_int(input int a, input int b);
        return (a < b) ? a : b;
    endfunction

    // Implemented width of each register
    function automatic ahb_word_t reg_mask(input reg_off_t off);
        case (off)
            REG_CTRL: return 32'h7;                         // Enable plus mode
            REG_DEAD: return 32'hF;
            default:  return ahb_word_t'((1 << pwm_width) - 1);
        endcase
    endfunction

    task automatic check_eq(input string what, input int unsigned expv, input int unsigned gotv);
        checks++;
        assert (gotv == expv) else begin
            $display("Error: %s, %s expected %0d actual %0d", cur_test, what, expv, gotv);
            errors++;
            test_errs++;
        end
    endtask

    task automatic start_test(input string name);
        cur_test  = name;
        test_errs = 0;
    endtask

    task automatic finish_test();
        $display("Test %s: %s with %0d errors", cur_test, (test_errs == 0) ? "ok" : "bad",
                 test_errs);
    endtask

    // Status 0 is zero-wait OKAY, 1 a clean two-cycle ERROR, 2 anything else
    task automatic bus_transfer(input reg_off_t off, input logic wr, input ahb_word_t wdata,
                                output ahb_word_t rdata, output int status);
        int     waits;
        logic   first_err;
        logic   first_ok;
        @(negedge hclk);
        haddr  = {27'b0, off, 2'b00};                       // Address phase
        htrans = HTRANS_NONSEQ;
        hwrite = wr;
        hsel   = 1'b1;
        @(negedge hclk);
        htrans = HTRANS_IDLE;                               // Data phase
        hsel   = 1'b0;
        hwdata = wdata;
        hready = hreadyout;                                 // Interconnect feeds ready back
        first_err = (hresp == HRESP_ERROR) && !hreadyout;
        first_ok  = (hresp == HRESP_OKAY) && hreadyout;
        waits     = 0;
        while (!hreadyout && waits < 8) begin
            @(negedge hclk);
            hready = hreadyout;
            waits++;
        end
        if (!hreadyout) begin
            $display("Transfer to offset %0d never completed, hreadyout stuck low", off);
            errors++;
            test_errs++;
        end
        rdata = hrdata;
        if (first_ok)
            status = 0;
        else if (first_err && waits == 1 && hresp == HRESP_ERROR)
            status = 1;
        else
            status = 2;
        @(posedge hclk);                                    // Data phase ends
    endtask

    task automatic ahb_write(input reg_off_t off, input ahb_word_t data, output int status);
        ahb_word_t dummy;
        bus_transfer(off, 1'b1, data, dummy, status);
    endtask

    task automatic ahb_read(input reg_off_t off, output ahb_word_t data, output int status);
        bus_transfer(off, 1'b0, 32'h0, data, status);
    endtask

    task automatic write_ok(input reg_off_t off, input ahb_word_t data);
        int st;
        ahb_write(off, data, st);
        check_eq("write response", 0, st);
    endtask

    task automatic settle(input int clks);
        repeat (clks) @(negedge hclk);
    endtask

    // Both pins counted from the same clock, each over its own window
    task automatic count_high(input int win_a, input int win_b, output int ha, output int hb);
        ha = 0;
        hb = 0;
        for (int i = 0; i < ((win_a > win_b) ? win_a : win_b); i++) begin
            @(negedge hclk);
            if (i < win_a && pwm_a) ha++;
            if (i < win_b && pwm_b) hb++;
        end
    endtask

    task automatic configure(input int pa, input int da, input int pb, input int db,
                             input int dt, input pwm_mode_t mode);
        write_ok(REG_PERIOD_A, ahb_word_t'(pa));
        write_ok(REG_DUTY_A, ahb_word_t'(da));
        write_ok(REG_PERIOD_B, ahb_word_t'(pb));
        write_ok(REG_DUTY_B, ahb_word_t'(db));
        write_ok(REG_DEAD, ahb_word_t'(dt));
        write_ok(REG_CTRL, {29'b0, mode, 1'b1});            // Enable goes last
    endtask

    task automatic test_readback();
        reg_off_t   off;
        ahb_word_t  val;
        ahb_word_t  got;
        int         st;
        start_test("readback");
        for (int i = 0; i < 6; i++) begin
            off = reg_off_t'(i);
            val = next_rand();
            write_ok(off, val);
            shadow[off] = val & reg_mask(off);
            ahb_read(off, got, st);
            check_eq("read response", 0, st);
            check_eq($sformatf("offset %0d", i), shadow[off], got);
        end
        write_ok(REG_CTRL, 32'h0);                          // Stop the channels again
        shadow[REG_CTRL] = 32'h0;
        finish_test();
    endtask

    task automatic test_unmapped();
        reg_off_t   off;
        ahb_word_t  got;
        int         st;
        start_test("unmapped");
        ahb_read(reg_off_t'(6), got, st);
        check_eq("read offset 6 response", 1, st);
        check_eq("read offset 6 data", 0, got);
        ahb_write(reg_off_t'(7), 32'hFFFF_FFFF, st);
        check_eq("write offset 7 response", 1, st);
        for (int i = 0; i < 6; i++) begin
            off = reg_off_t'(i);
            ahb_read(off, got, st);
            check_eq($sformatf("offset %0d after dropped write", i), shadow[off], got);
        end
        finish_test();
    endtask

    task automatic test_indep();
        int pa, da, pb, db;
        int ha, hb;
        start_test("indep");
        for (int i = 0; i < 4; i++) begin
            pa = int'(next_rand() % period_max) + 1;
            pb = int'(next_rand() % period_max) + 1;
            da = (i == 0) ? 0 : (i == 1) ? pa + 7 : int'(next_rand() % (pa + 3));
            db = (i == 1) ? 0 : (i == 0) ? pb + 4 : int'(next_rand() % (pb + 3));
            configure(pa, da, pb, db, 0, MODE_INDEP);
            settle(8);
            count_high(k_periods * (pa + 1), k_periods * (pb + 1), ha, hb);
            check_eq($sformatf("pwm_a period %0d duty %0d", pa, da),
                     k_periods * min_int(da, pa + 1), ha);
            check_eq($sformatf("pwm_b period %0d duty %0d", pb, db),
                     k_periods * min_int(db, pb + 1), hb);
            write_ok(REG_CTRL, 32'h0);
        end
        finish_test();
    endtask

    task automatic test_compl();
        int pa, da, dt;
        int ha, hb;
        start_test("compl");
        for (int i = 0; i < 2; i++) begin
            dt = int'(next_rand() % 4) + 1;
            pa = 20 + int'(next_rand() % 20);
            da = dt + 2 + int'(next_rand() % (pa - 2 * dt - 3));  // Both phases outlast dead
            configure(pa, da, 0, 0, dt, MODE_COMPL);
            settle(8);
            count_high(k_periods * (pa + 1), k_periods * (pa + 1), ha, hb);
            check_eq($sformatf("pwm_a duty %0d dead %0d", da, dt), k_periods * (da - dt), ha);
            check_eq($sformatf("pwm_b duty %0d dead %0d", da, dt),
                     k_periods * (pa + 1 - da - dt), hb);
            write_ok(REG_CTRL, 32'h0);
        end
        finish_test();
    endtask

    task automatic test_gated();
        int pa, da, pb, db;
        int viol;
        int ha;
        int hb;
        start_test("gated");
        pa   = int'(next_rand() % period_max) + 1;
        pb   = int'(next_rand() % period_max) + 1;
        da   = pa + 1 + int'(next_rand() % 4);              // Above period, A stays high
        db   = int'(next_rand() % pb) + 1;                  // B keeps some low time
        viol = 0;
        ha   = 0;
        hb   = 0;
        configure(pa, da, pb, db, 0, MODE_GATED);
        settle(8);
        for (int i = 0; i < k_periods * (pb + 1); i++) begin
            @(negedge hclk);
            if (pwm_a && !pwm_b) viol++;                    // A must be masked by B
            if (pwm_a) ha++;
            if (pwm_b) hb++;
        end
        check_eq("samples with pwm_a high and pwm_b low", 0, viol);
        check_eq("pwm_a high count", k_periods * db, ha);
        check_eq("pwm_b high count", k_periods * min_int(db, pb + 1), hb);
        write_ok(REG_CTRL, 32'h0);
        finish_test();
    endtask

    task automatic test_disable();
        int pa, pb;
        int ha, hb;
        start_test("disable");
        pa = int'(next_rand() % period_max) + 1;
        pb = int'(next_rand() % period_max) + 1;
        configure(pa, pa, pb, pb, 0, MODE_INDEP);           // Duty equal to period, mostly high
        settle(10);
        write_ok(REG_CTRL, 32'h0);
        settle(4);
        count_high(pa + 1, pb + 1, ha, hb);
        check_eq("pwm_a high while disabled", 0, ha);
        check_eq("pwm_b high while disabled", 0, hb);
        finish_test();
    endtask

    // Watchdog
    initial begin
        #(budget_clks * 2 * clk_half);
        $display("Timeout: the tests did not finish within %0d clocks", budget_clks);
        $display("CHECKS FAILED");
        $finish;
    end

    initial begin
        rst_n  = 1'b0;
        haddr  = '0;
        htrans = HTRANS_IDLE;
        hwrite = 1'b0;
        hsel   = 1'b0;
        hready = 1'b1;
        hwdata = '0;
        errors = 0;
        checks = 0;
        repeat (10) @(posedge hclk);
        @(negedge hclk);
        rst_n = 1'b1;
        test_readback();
        test_unmapped();
        test_indep();
        test_compl();
        test_gated();
        test_disable();
        $display("Summary: %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule : ahb_pwm_tb

// ==== ahb_pwm_top.f ====
source/ahb_defs_pkg.sv
source/pwm_defs_pkg.sv
source/pwm_cfg_if.sv
source/ahb_pwm_regs.sv
source/pwm_channel.sv
source/pwm_output_mix.sv
source/ahb_pwm_top.sv
verification/ahb_pwm_assert.sv
verification/ahb_pwm_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the PWM testbench with Verilator, verdict taken from the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log
rm -rf obj_dir "$LOG"

verilator --binary --timing --assert -j 0 --top-module ahb_pwm_tb -f ahb_pwm_top.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/Vahb_pwm_tb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -qx "ALL CHECKS PASSED" "$LOG"; then
    echo "Simulation passed"
    exit 0
else
    echo "Simulation failed"
    exit 1
fi
